// File: filelist.f
+incdir+hw
hw/dcache_pkg.sv
hw/dp_ram.sv
hw/dcache_tag_store.sv
hw/dcache_data_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/mem_responder.sv
sim/tb_dcache.sv

// File: sim/tb_dcache.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int NUM_OPS = 300;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 60 + 200;
    localparam int MEM_WORDS = 2 ** (`DC_AW - `DC_OFFSET_W);
    localparam int IDX_LSB = `DC_OFFSET_W + `DC_BLOCK_W;

    logic clk;
    logic resetn;
    logic cpu_req;
    logic cpu_we;
    addr_t cpu_adr;
    word_t cpu_dat;
    logic [`DC_BYTES-1:0] cpu_sel;
    logic cpu_ack;
    word_t cpu_rdat;
    logic mem_ready;
    logic mem_wb_ack;
    logic mem_rsp_valid;
    mem_rsp_e mem_rsp_type;
    word_t mem_rsp_data;
    logic mem_rsp_ack;
    logic mem_req_valid;
    mem_req_e mem_req_type;
    addr_t mem_req_adr;
    word_t mem_req_data;

    // Memory contents as the CPU should see them
    word_t model_mem [MEM_WORDS];
    integer seed;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    int ops_done = 0;
    int loads = 0;
    int stores = 0;
    int wb_bursts = 0;
    int wb_left = 0;
    addr_t wb_base;
    addr_t cur_adr;
    logic req_pending = 1'b0;

    dcache_top u_dut (
        .clk             (clk),
        .resetn          (resetn),
        .cpu_req_i       (cpu_req),
        .cpu_we_i        (cpu_we),
        .cpu_adr_i       (cpu_adr),
        .cpu_dat_i       (cpu_dat),
        .cpu_sel_i       (cpu_sel),
        .cpu_ack_o       (cpu_ack),
        .cpu_dat_o       (cpu_rdat),
        .mem_ready_i     (mem_ready),
        .mem_wb_ack_i    (mem_wb_ack),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_type_i  (mem_rsp_type),
        .mem_rsp_data_i  (mem_rsp_data),
        .mem_rsp_ack_o   (mem_rsp_ack),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_type_o  (mem_req_type),
        .mem_req_adr_o   (mem_req_adr),
        .mem_req_data_o  (mem_req_data)
    );

    mem_responder #(
        .SEED (32'hc356_a6c1)
    ) u_mem (
        .clk             (clk),
        .resetn          (resetn),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_type_i  (mem_req_type),
        .mem_req_adr_i   (mem_req_adr),
        .mem_req_data_i  (mem_req_data),
        .mem_rsp_ack_i   (mem_rsp_ack),
        .mem_ready_o     (mem_ready),
        .mem_wb_ack_o    (mem_wb_ack),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_type_o  (mem_rsp_type),
        .mem_rsp_data_o  (mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        checks++;
        assert (got === expected) else begin
            $display("FAIL t=%0t %s: got 0x%h, expected 0x%h", $time, name, got, expected);
            errors++;
        end
    endtask

    // The model starts from the same contents as the memory behind the cache
    task automatic load_model();
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = u_mem.ref_mem[i];
        end
    endtask

    task automatic check_request();
        checks += 2;
        assert (mem_ready === 1'b1) else begin
            $display("Memory request at %0t was issued while mem_ready_i was low", $time);
            errors++;
        end
        assert (req_pending) else begin
            $display("Memory request at %0t was issued with no CPU request pending", $time);
            errors++;
        end
        if (mem_req_type == MEM_READ) begin
            check_value("mem_req_adr_o", mem_req_adr, cur_adr);
        end else begin
            checks++;
            assert (mem_req_adr[IDX_LSB-1:0] == '0) else begin
                $display("Victim address 0x%h at %0t is not line aligned", mem_req_adr, $time);
                errors++;
            end
            check_value("mem_req_adr_o index", mem_req_adr[IDX_LSB +: `DC_INDEX_W],
                        cur_adr[IDX_LSB +: `DC_INDEX_W]);
            if (mem_req_type == MEM_WRITE_BACK) begin
                wb_left = `DC_WORDS;
                wb_base = mem_req_adr;
                wb_bursts++;
            end
        end
    endtask

    task automatic check_wb_beat();
        int unsigned widx;
        widx = (wb_base >> `DC_OFFSET_W) + (`DC_WORDS - wb_left);
        checks++;
        assert (mem_req_valid === 1'b1 && mem_req_type == MEM_WRITE_BACK) else begin
            $display("Write-back burst to 0x%h broke off at %0t with %0d beats missing",
                     wb_base, $time, wb_left);
            errors++;
        end
        if (mem_req_valid === 1'b1) begin
            check_value("mem_req_adr_o", mem_req_adr, wb_base);
            check_value("mem_req_data_o", mem_req_data, model_mem[widx]);
        end
        wb_left--;
    endtask

    always @(posedge clk) begin
        if (resetn === 1'b1) begin
            if (cpu_ack !== 1'b0) begin
                checks++;
                assert (cpu_ack === 1'b1 && cpu_req === 1'b1) else begin
                    $display("CPU ack at %0t came without a CPU request held", $time);
                    errors++;
                end
            end
            if (mem_rsp_ack !== 1'b0) begin
                checks++;
                assert (mem_rsp_ack === 1'b1 && mem_rsp_valid === 1'b1) else begin
                    $display("Response ack at %0t came without a valid response", $time);
                    errors++;
                end
            end
            // Request beats and write-back beats are told apart by the beats still due
            if (wb_left > 0) begin
                check_wb_beat();
            end else if (mem_req_valid === 1'b1) begin
                check_request();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d operations acknowledged",
                     cycle_count, ops_done, NUM_OPS);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic run_op(input int n);
        logic [31:0] rnd;
        logic [`DC_TAG_W-1:0] tag;
        addr_t adr;
        word_t wdat;
        logic we;
        logic [`DC_BYTES-1:0] sel;
        int unsigned widx;
        int errors_before;
        // Three tags share every set, so two ways are not enough and lines get evicted
        rnd  = $random(seed);
        tag  = rnd[31:16] % 3;
        adr  = {tag, rnd[IDX_LSB+`DC_INDEX_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        rnd  = $random(seed);
        we   = rnd[0];
        sel  = rnd[`DC_BYTES:1];
        wdat = $random(seed);
        widx = adr >> `DC_OFFSET_W;
        errors_before = errors;

        @(negedge clk);
        cpu_req = 1'b1;
        cpu_we  = we;
        cpu_adr = adr;
        cpu_dat = wdat;
        cpu_sel = sel;
        cur_adr = adr;
        req_pending = 1'b1;
        do begin
            @(posedge clk);
        end while (cpu_ack !== 1'b1);
        req_pending = 1'b0;

        if (we) begin
            for (int b = 0; b < `DC_BYTES; b++) begin
                if (sel[b]) begin
                    model_mem[widx][b*8 +: 8] = wdat[b*8 +: 8];
                end
            end
            stores++;
        end else begin
            check_value("cpu_dat_o", cpu_rdat, model_mem[widx]);
            loads++;
        end
        ops_done++;
        $display("op %0d %s adr 0x%h sel %b data 0x%h %s", n, we ? "store" : "load ",
                 adr, sel, we ? wdat : cpu_rdat, (errors == errors_before) ? "ok" : "error");

        // Some operations are followed by an idle cycle
        if (rnd[6:5] == 2'b00) begin
            @(negedge clk);
            cpu_req = 1'b0;
        end
    endtask

    initial begin
        seed    = 32'hc356_a6c1;
        resetn  = 1'b0;
        cpu_req = 1'b0;
        cpu_we  = 1'b0;
        cpu_adr = '0;
        cpu_dat = '0;
        cpu_sel = '0;
        repeat (16) @(posedge clk);
        load_model();
        @(negedge clk);
        resetn = 1'b1;

        for (int n = 0; n < NUM_OPS; n++) begin
            run_op(n);
        end
        repeat (4) @(posedge clk);

        $display("Operations %0d, loads %0d, stores %0d, write-backs %0d, checks %0d, errors %0d",
                 ops_done, loads, stores, wb_bursts, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim/mem_responder.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module mem_responder import dcache_pkg::*; #(
    parameter int unsigned SEED = 32'hc356_a6c1
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     mem_req_valid_i,
    input  mem_req_e mem_req_type_i,
    input  addr_t    mem_req_adr_i,
    input  word_t    mem_req_data_i,
    input  logic     mem_rsp_ack_i,
    output logic     mem_ready_o,
    output logic     mem_wb_ack_o,
    output logic     mem_rsp_valid_o,
    output mem_rsp_e mem_rsp_type_o,
    output word_t    mem_rsp_data_o
);

    localparam int MEM_WORDS = 2 ** (`DC_AW - `DC_OFFSET_W);
    localparam int IDX_LSB = `DC_OFFSET_W + `DC_BLOCK_W;

    // Backing memory with one entry per word
    word_t ref_mem [MEM_WORDS];
    integer seed;
    mem_req_e req_type;
    int unsigned line_base;
    int unsigned delay;

    // Every word gets a value that depends on all of its address bits
    function automatic word_t fill_pattern(input int unsigned widx);
        return ((widx + 32'd1) * 32'h9e37_79b1) ^ (widx << 16);
    endfunction

    initial begin
        seed = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = fill_pattern(i);
        end
        mem_ready_o     = 1'b1;
        mem_wb_ack_o    = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_type_o  = RSP_REPLACE_OK;
        mem_rsp_data_o  = '0;
    end

    // The line words follow the request beat on the next DC_WORDS rising edges
    task take_write_back();
        for (int k = 0; k < `DC_WORDS; k++) begin
            @(posedge clk);
            if (mem_req_valid_i && mem_req_type_i == MEM_WRITE_BACK) begin
                ref_mem[line_base + k] = mem_req_data_i;
            end
            if (k == 0) begin
                @(negedge clk);
                mem_wb_ack_o = 1'b0;
            end
        end
    endtask

    always begin
        @(posedge clk);
        if (resetn && mem_req_valid_i) begin
            req_type  = mem_req_type_i;
            line_base = (mem_req_adr_i >> IDX_LSB) << `DC_BLOCK_W;
            @(negedge clk);
            mem_ready_o = 1'b0;
            if (req_type == MEM_WRITE_BACK) begin
                mem_wb_ack_o = 1'b1;
                take_write_back();
            end
            delay = 1 + ($unsigned($random(seed)) % 8);
            repeat (delay) @(negedge clk);
            mem_rsp_valid_o = 1'b1;
            mem_rsp_type_o  = (req_type == MEM_READ) ? RSP_READ_OK : RSP_REPLACE_OK;
            mem_rsp_data_o  = ref_mem[line_base];
            do begin
                @(posedge clk);
            end while (mem_rsp_ack_i !== 1'b1);
            @(negedge clk);
            mem_rsp_valid_o = 1'b0;
            if (req_type == MEM_READ) begin
                // The remaining words of the line follow one per cycle after the ack
                for (int k = 1; k < `DC_WORDS; k++) begin
                    mem_rsp_data_o = ref_mem[line_base + k];
                    @(negedge clk);
                end
            end
            mem_ready_o = 1'b1;
        end
    end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 cpu_req_i,
    input  logic                 cpu_we_i,
    input  addr_t                cpu_adr_i,
    input  word_t                cpu_dat_i,
    input  logic [`DC_BYTES-1:0] cpu_sel_i,
    output logic                 cpu_ack_o,
    output word_t                cpu_dat_o,
    input  logic                 mem_ready_i,
    input  logic                 mem_wb_ack_i,
    input  logic                 mem_rsp_valid_i,
    input  mem_rsp_e             mem_rsp_type_i,
    input  word_t                mem_rsp_data_i,
    output logic                 mem_rsp_ack_o,
    output logic                 mem_req_valid_o,
    output mem_req_e             mem_req_type_o,
    output addr_t                mem_req_adr_o,
    output word_t                mem_req_data_o
);

    logic tag_rd_en;
    logic [`DC_INDEX_W-1:0] tag_index;
    logic [`DC_TAG_W-1:0] lookup_tag;
    logic tag_wr_en;
    way_t tag_wr_way;
    logic tag_wr_valid;
    logic tag_wr_dirty;
    logic [`DC_TAG_W-1:0] tag_wr_tag;
    logic ptr_advance;
    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_valid;
    logic victim_dirty;
    logic [`DC_TAG_W-1:0] victim_tag;

    logic data_rd_en;
    logic [`DC_INDEX_W+`DC_BLOCK_W-1:0] data_rd_adr;
    way_t data_rd_way;
    word_t data_rd_dat;
    logic data_wr_en;
    way_t data_wr_way;
    logic [`DC_INDEX_W+`DC_BLOCK_W-1:0] data_wr_adr;
    word_t data_wr_dat;
    logic [`DC_BYTES-1:0] data_wr_sel;

    // CPU and memory ports share their names with the top
    dcache_ctrl u_ctrl (
        .tag_rd_en_o    (tag_rd_en),
        .tag_index_o    (tag_index),
        .lookup_tag_o   (lookup_tag),
        .tag_wr_en_o    (tag_wr_en),
        .tag_wr_way_o   (tag_wr_way),
        .tag_wr_valid_o (tag_wr_valid),
        .tag_wr_dirty_o (tag_wr_dirty),
        .tag_wr_tag_o   (tag_wr_tag),
        .ptr_advance_o  (ptr_advance),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_valid_i (victim_valid),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .data_rd_en_o   (data_rd_en),
        .data_rd_adr_o  (data_rd_adr),
        .data_rd_way_o  (data_rd_way),
        .data_wr_en_o   (data_wr_en),
        .data_wr_way_o  (data_wr_way),
        .data_wr_adr_o  (data_wr_adr),
        .data_wr_dat_o  (data_wr_dat),
        .data_wr_sel_o  (data_wr_sel),
        .data_rd_dat_i  (data_rd_dat),
        .*
    );

    dcache_tag_store u_tag_store (
        .clk            (clk),
        .rd_en_i        (tag_rd_en),
        .index_i        (tag_index),
        .lookup_tag_i   (lookup_tag),
        .wr_en_i        (tag_wr_en),
        .wr_way_i       (tag_wr_way),
        .wr_valid_i     (tag_wr_valid),
        .wr_dirty_i     (tag_wr_dirty),
        .wr_tag_i       (tag_wr_tag),
        .ptr_advance_i  (ptr_advance),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_valid_o (victim_valid),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_store u_data_store (
        .clk      (clk),
        .rd_en_i  (data_rd_en),
        .rd_adr_i (data_rd_adr),
        .rd_way_i (data_rd_way),
        .rd_dat_o (data_rd_dat),
        .wr_en_i  (data_wr_en),
        .wr_way_i (data_wr_way),
        .wr_adr_i (data_wr_adr),
        .wr_dat_i (data_wr_dat),
        .wr_sel_i (data_wr_sel)
    );

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 cpu_req_i,
    input  logic                                 cpu_we_i,
    input  addr_t                                cpu_adr_i,
    input  word_t                                cpu_dat_i,
    input  logic [`DC_BYTES-1:0]                 cpu_sel_i,
    output logic                                 cpu_ack_o,
    output word_t                                cpu_dat_o,
    input  logic                                 mem_ready_i,
    input  logic                                 mem_wb_ack_i,
    input  logic                                 mem_rsp_valid_i,
    input  mem_rsp_e                             mem_rsp_type_i,
    input  word_t                                mem_rsp_data_i,
    output logic                                 mem_rsp_ack_o,
    output logic                                 mem_req_valid_o,
    output mem_req_e                             mem_req_type_o,
    output addr_t                                mem_req_adr_o,
    output word_t                                mem_req_data_o,
    output logic                                 tag_rd_en_o,
    output logic [`DC_INDEX_W-1:0]               tag_index_o,
    output logic [`DC_TAG_W-1:0]                 lookup_tag_o,
    output logic                                 tag_wr_en_o,
    output way_t                                 tag_wr_way_o,
    output logic                                 tag_wr_valid_o,
    output logic                                 tag_wr_dirty_o,
    output logic [`DC_TAG_W-1:0]                 tag_wr_tag_o,
    output logic                                 ptr_advance_o,
    input  logic                                 hit_i,
    input  way_t                                 hit_way_i,
    input  way_t                                 victim_way_i,
    input  logic                                 victim_valid_i,
    input  logic                                 victim_dirty_i,
    input  logic [`DC_TAG_W-1:0]                 victim_tag_i,
    output logic                                 data_rd_en_o,
    output logic [`DC_INDEX_W+`DC_BLOCK_W-1:0]   data_rd_adr_o,
    output way_t                                 data_rd_way_o,
    output logic                                 data_wr_en_o,
    output way_t                                 data_wr_way_o,
    output logic [`DC_INDEX_W+`DC_BLOCK_W-1:0]   data_wr_adr_o,
    output word_t                                data_wr_dat_o,
    output logic [`DC_BYTES-1:0]                 data_wr_sel_o,
    input  word_t                                data_rd_dat_i
);

    localparam int IDX_LSB = `DC_OFFSET_W + `DC_BLOCK_W;

    ctrl_state_e state_q, state_d;
    logic [`DC_BLOCK_W-1:0] wb_ptr_q, wb_ptr_d;
    logic [`DC_BLOCK_W-1:0] fill_ptr_q, fill_ptr_d;

    addr_t adr_q;
    word_t dat_q;
    logic [`DC_BYTES-1:0] sel_q;
    mem_rsp_e rsp_type_q;
    word_t rsp_data_q;

    logic rsp_take;
    logic cpu_take;
    logic [`DC_INDEX_W-1:0] index_q;
    logic [`DC_BLOCK_W-1:0] block_q;
    addr_t victim_base;

    // A pending response wins over the CPU in IDLE
    assign rsp_take = (state_q == IDLE) && mem_rsp_valid_i;
    assign cpu_take = (state_q == IDLE) && !mem_rsp_valid_i && cpu_req_i;
    assign mem_rsp_ack_o = rsp_take;

    assign index_q      = adr_q[IDX_LSB +: `DC_INDEX_W];
    assign block_q      = adr_q[`DC_OFFSET_W +: `DC_BLOCK_W];
    assign lookup_tag_o = adr_q[`DC_AW-1 -: `DC_TAG_W];
    assign victim_base  = {victim_tag_i, index_q, {IDX_LSB{1'b0}}};

    assign cpu_dat_o      = data_rd_dat_i;
    assign mem_req_data_o = data_rd_dat_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q    <= IDLE;
            wb_ptr_q   <= '0;
            fill_ptr_q <= '0;
        end else begin
            state_q    <= state_d;
            wb_ptr_q   <= wb_ptr_d;
            fill_ptr_q <= fill_ptr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_take) begin
            adr_q <= cpu_adr_i;
            dat_q <= cpu_dat_i;
            sel_q <= cpu_sel_i;
        end
        if (rsp_take) begin
            rsp_type_q <= mem_rsp_type_i;
        end
        // Fill words come back to back, so RSP and FILL use the word of the cycle before
        rsp_data_q <= mem_rsp_data_i;
    end

    always_comb begin
        state_d    = state_q;
        wb_ptr_d   = wb_ptr_q;
        fill_ptr_d = fill_ptr_q;

        cpu_ack_o       = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_req_type_o  = MEM_READ;
        mem_req_adr_o   = victim_base;

        tag_rd_en_o    = 1'b0;
        tag_index_o    = index_q;
        tag_wr_en_o    = 1'b0;
        tag_wr_way_o   = victim_way_i;
        tag_wr_valid_o = 1'b0;
        tag_wr_dirty_o = 1'b0;
        tag_wr_tag_o   = lookup_tag_o;
        ptr_advance_o  = 1'b0;

        data_rd_en_o  = 1'b0;
        data_rd_adr_o = {index_q, block_q};
        data_rd_way_o = victim_way_i;
        data_wr_en_o  = 1'b0;
        data_wr_way_o = victim_way_i;
        data_wr_adr_o = {index_q, block_q};
        data_wr_dat_o = rsp_data_q;
        data_wr_sel_o = '1;

        case (state_q)
            IDLE: begin
                if (rsp_take) begin
                    tag_rd_en_o = 1'b1;
                    state_d     = RSP;
                end else if (cpu_take) begin
                    tag_rd_en_o   = 1'b1;
                    tag_index_o   = cpu_adr_i[IDX_LSB +: `DC_INDEX_W];
                    data_rd_en_o  = 1'b1;
                    data_rd_adr_o = cpu_adr_i[`DC_OFFSET_W +: `DC_INDEX_W + `DC_BLOCK_W];
                    state_d       = cpu_we_i ? STORE : LOAD;
                end
            end
            LOAD, STORE: begin
                data_rd_way_o = hit_way_i;
                state_d       = IDLE;
                if (hit_i) begin
                    cpu_ack_o = 1'b1;
                    if (state_q == STORE) begin
                        data_wr_en_o   = 1'b1;
                        data_wr_way_o  = hit_way_i;
                        data_wr_dat_o  = dat_q;
                        data_wr_sel_o  = sel_q;
                        tag_wr_en_o    = 1'b1;
                        tag_wr_way_o   = hit_way_i;
                        tag_wr_valid_o = 1'b1;
                        tag_wr_dirty_o = 1'b1;
                    end
                end else if (mem_ready_i) begin
                    // On a miss the request type depends on the state of the victim line
                    mem_req_valid_o = 1'b1;
                    if (!victim_valid_i) begin
                        mem_req_type_o = MEM_READ;
                        mem_req_adr_o  = adr_q;
                    end else if (victim_dirty_i) begin
                        mem_req_type_o = MEM_WRITE_BACK;
                        wb_ptr_d       = '0;
                        data_rd_en_o   = 1'b1;
                        data_rd_adr_o  = {index_q, wb_ptr_d};
                        state_d        = WB_ACK;
                    end else begin
                        mem_req_type_o = MEM_EVICT;
                    end
                end
            end
            WB_ACK, WB_DATA: begin
                if (state_q == WB_ACK && !mem_wb_ack_i) begin
                    state_d = IDLE;
                end else begin
                    mem_req_valid_o = 1'b1;
                    mem_req_type_o  = MEM_WRITE_BACK;
                    wb_ptr_d        = wb_ptr_q + 1'b1;
                    data_rd_en_o    = 1'b1;
                    data_rd_adr_o   = {index_q, wb_ptr_d};
                    // The pointer wraps after the last word of the line
                    state_d         = (wb_ptr_d == '0) ? IDLE : WB_DATA;
                end
            end
            RSP: begin
                if (rsp_type_q == RSP_REPLACE_OK) begin
                    // The victim is dropped and the pointer stays on it for the fill that follows
                    tag_wr_en_o = 1'b1;
                    state_d     = IDLE;
                end else begin
                    fill_ptr_d    = '0;
                    data_wr_en_o  = 1'b1;
                    data_wr_adr_o = {index_q, fill_ptr_d};
                    state_d       = FILL;
                end
            end
            FILL: begin
                fill_ptr_d    = fill_ptr_q + 1'b1;
                data_wr_en_o  = 1'b1;
                data_wr_adr_o = {index_q, fill_ptr_d};
                if (fill_ptr_d == (`DC_WORDS - 1)) begin
                    tag_wr_en_o    = 1'b1;
                    tag_wr_valid_o = 1'b1;
                    ptr_advance_o  = 1'b1;
                    state_d        = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

// File: hw/dcache_data_store.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_data_store import dcache_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rd_en_i,
    input  logic [`DC_INDEX_W+`DC_BLOCK_W-1:0]   rd_adr_i,
    input  way_t                                 rd_way_i,
    output word_t                                rd_dat_o,
    input  logic                                 wr_en_i,
    input  way_t                                 wr_way_i,
    input  logic [`DC_INDEX_W+`DC_BLOCK_W-1:0]   wr_adr_i,
    input  word_t                                wr_dat_i,
    input  logic [`DC_BYTES-1:0]                 wr_sel_i
);

    word_t way_rd [`DC_WAYS];
    word_t wr_merged;

    // Unselected bytes keep the value read from the same way in the cycle before
    always_comb begin
        wr_merged = way_rd[wr_way_i];
        for (int b = 0; b < `DC_BYTES; b++) begin
            if (wr_sel_i[b]) begin
                wr_merged[b*8 +: 8] = wr_dat_i[b*8 +: 8];
            end
        end
    end

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dp_ram #(
            .ADDR_W (`DC_INDEX_W + `DC_BLOCK_W),
            .DATA_W (`DC_DW)
        ) u_way_ram (
            .clk      (clk),
            .rd_en_i  (rd_en_i),
            .rd_adr_i (rd_adr_i),
            .rd_dat_o (way_rd[w]),
            .wr_en_i  (wr_en_i && (wr_way_i == way_t'(w))),
            .wr_adr_i (wr_adr_i),
            .wr_dat_i (wr_merged)
        );
    end

    // All ways are read together and the way is picked once it is known
    assign rd_dat_o = way_rd[rd_way_i];

endmodule

// File: hw/dcache_tag_store.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_tag_store import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rd_en_i,
    input  logic [`DC_INDEX_W-1:0] index_i,
    input  logic [`DC_TAG_W-1:0] lookup_tag_i,
    input  logic                 wr_en_i,
    input  way_t                 wr_way_i,
    input  logic                 wr_valid_i,
    input  logic                 wr_dirty_i,
    input  logic [`DC_TAG_W-1:0] wr_tag_i,
    input  logic                 ptr_advance_i,
    output logic                 hit_o,
    output way_t                 hit_way_o,
    output way_t                 victim_way_o,
    output logic                 victim_valid_o,
    output logic                 victim_dirty_o,
    output logic [`DC_TAG_W-1:0] victim_tag_o
);

    // A set holds {ptr, way N-1 ... way 0} and packs each way as {dirty, valid, tag}
    localparam int WAY_FIELD_W = `DC_TAG_W + 2;
    localparam int PTR_LSB = `DC_WAYS * WAY_FIELD_W;
    localparam int SET_W = PTR_LSB + $bits(way_t);

    logic [SET_W-1:0] set_rd;
    logic [SET_W-1:0] set_wr;
    logic [`DC_WAYS-1:0][`DC_TAG_W-1:0] way_tag;
    logic [`DC_WAYS-1:0] way_valid;
    logic [`DC_WAYS-1:0] way_dirty;
    logic [`DC_WAYS-1:0] way_hit;
    way_t ptr;

    dp_ram #(
        .ADDR_W ($clog2(`DC_SETS)),
        .DATA_W (SET_W)
    ) u_tag_ram (
        .clk      (clk),
        .rd_en_i  (rd_en_i),
        .rd_adr_i (index_i),
        .rd_dat_o (set_rd),
        .wr_en_i  (wr_en_i),
        .wr_adr_i (index_i),
        .wr_dat_i (set_wr)
    );

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_tag[w]   = set_rd[w*WAY_FIELD_W +: `DC_TAG_W];
            way_valid[w] = set_rd[w*WAY_FIELD_W + `DC_TAG_W];
            way_dirty[w] = set_rd[w*WAY_FIELD_W + `DC_TAG_W + 1];
            way_hit[w]   = way_valid[w] && (way_tag[w] == lookup_tag_i);
        end
        ptr = set_rd[PTR_LSB +: $bits(way_t)];
    end

    assign hit_o = |way_hit;

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way_o = way_t'(w);
            end
        end
    end

    // The round-robin pointer names the next way to replace
    assign victim_way_o   = ptr;
    assign victim_valid_o = way_valid[ptr];
    assign victim_dirty_o = way_dirty[ptr];
    assign victim_tag_o   = way_tag[ptr];

    // A write rewrites the set read last, with one way's fields replaced
    always_comb begin
        set_wr = set_rd;
        set_wr[wr_way_i*WAY_FIELD_W +: WAY_FIELD_W] = {wr_dirty_i, wr_valid_i, wr_tag_i};
        set_wr[PTR_LSB +: $bits(way_t)] = ptr + way_t'(ptr_advance_i);
    end

endmodule

// File: hw/dp_ram.sv
`timescale 1ns/10ps

module dp_ram #(
    parameter int ADDR_W = 4,
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_adr_i,
    output logic [DATA_W-1:0] rd_dat_o,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_adr_i,
    input  logic [DATA_W-1:0] wr_dat_i
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    // All entries start at zero, so every line comes up invalid
    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_adr_i] <= wr_dat_i;
        end
    end

    // Read data holds until the next read, even across writes
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_dat_o <= mem[rd_adr_i];
        end
    end

endmodule

// File: hw/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DC_AW-1:0] addr_t;
    typedef logic [`DC_DW-1:0] word_t;
    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        STORE,
        WB_ACK,
        WB_DATA,
        RSP,
        FILL
    } ctrl_state_e;

    // Requests towards the memory side
    typedef enum logic [1:0] {
        MEM_READ,
        MEM_WRITE_BACK,
        MEM_EVICT
    } mem_req_e;

    // Responses from the memory side
    typedef enum logic {
        RSP_REPLACE_OK,
        RSP_READ_OK
    } mem_rsp_e;

endpackage

// File: hw/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// CPU bus
`define DC_AW 16
`define DC_DW 32
`define DC_BYTES 4

// Cache organization
`define DC_WAYS 2
`define DC_SETS 16
`define DC_WORDS 4

// The address splits from the top into tag, index, word in line and byte in word
`define DC_OFFSET_W 2
`define DC_BLOCK_W 2
`define DC_INDEX_W 4
`define DC_TAG_W 8

`endif
